// File: source/bch_pkg.sv
`default_nettype none

package bch_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Code constants for BCH(15,5) over GF(2^4).
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam int m = 4;
	localparam int t = 3;
	localparam int n = 15;

	// Low-order bits of the primitive polynomial x^4 + x + 1.
	localparam logic [m-1:0] prim_poly = 4'b0011;

	// Counter widths for the solver iteration, the solver degree and the Chien search.
	localparam int iter_w = $clog2(t);
	localparam int l_w = $clog2(2 * t);
	localparam int cnt_w = $clog2(n + 1);

	typedef logic [m-1:0] gf_elem;
	typedef logic [n-1:0] word_t;
	typedef gf_elem [2*t-1:0] syn_vec_t;
	typedef gf_elem [t:0] sigma_t;

	// Shift-and-add multiply, reducing by the field polynomial after every shift.
	function automatic gf_elem gf_mul(input gf_elem a, input gf_elem b);
		gf_elem prod;
		gf_elem shifted;
		prod = '0;
		shifted = a;
		for (int i = 0; i < m; i++) begin
			if (b[i])
				prod = prod ^ shifted;
			shifted = {shifted[m-2:0], 1'b0} ^ (shifted[m-1] ? prim_poly : '0);
		end
		return prod;
	endfunction

	// Alpha to the power e, with e reduced modulo the multiplicative order.
	function automatic gf_elem gf_alpha_pow(input int unsigned e);
		int unsigned r;
		gf_elem p;
		r = e % n;
		p = gf_elem'(1);
		for (int k = 0; k < n - 1; k++) begin
			if (k < r)
				p = gf_mul(p, gf_elem'(2));
		end
		return p;
	endfunction

endpackage

`default_nettype wire

// File: source/bch_syndrome.sv
`timescale 1ns/1ps
`default_nettype none

module bch_syndrome
	import bch_pkg::*;
(
	input wire clk,
	input wire rst,
	input wire start,
	input wire word_t received,
	output logic syn_start,
	output syn_vec_t syndromes,
	output word_t word_q
);

	syn_vec_t syn_next;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Syndrome evaluation.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Odd syndromes are the received polynomial evaluated at alpha^j.
	// For a binary code S_2k equals S_k squared, so the even ones come for
	// free once the lower index is known.
	always_comb begin
		syn_vec_t s;
		s = '0;
		for (int j = 1; j <= 2 * t; j++) begin
			if (j % 2 == 1) begin
				for (int i = 0; i < n; i++) begin
					if (received[i])
						s[j-1] = s[j-1] ^ gf_alpha_pow(j * i);
				end
			end else begin
				s[j-1] = gf_mul(s[j/2-1], s[j/2-1]);
			end
		end
		syn_next = s;
	end

	always_ff @(posedge clk) begin
		if (rst)
			syn_start <= 1'b0;
		else
			syn_start <= start;
	end

	// The word travels with its syndromes so the Chien search sees the same one.
	always_ff @(posedge clk) begin
		if (start) begin
			syndromes <= syn_next;
			word_q <= received;
		end
	end

endmodule

`default_nettype wire

// File: source/bch_syndrome_shuffle.sv
`timescale 1ns/1ps
`default_nettype none

module bch_syndrome_shuffle
	import bch_pkg::*;
(
	input wire clk,
	input wire start,
	input wire ce,
	input wire syn_vec_t syndromes,
	output gf_elem [2*t-2:0] window
);

	gf_elem [2*t-2:0] load_order;

	// Loaded as S1, S(2t-1), ..., S2. After r rotations element i holds
	// S(2r-i+1) wherever sigma_i can be nonzero; the other slots meet a zero
	// coefficient and do not matter.
	always_comb begin
		load_order[0] = syndromes[0];
		for (int j = 1; j < 2 * t - 1; j++)
			load_order[j] = syndromes[2*t-1-j];
	end

	// Each solver iteration moves the window up by two syndromes.
	always_ff @(posedge clk) begin
		if (start)
			window <= load_order;
		else if (ce)
			window <= {window[2*t-4:0], window[2*t-2:2*t-3]};
	end

endmodule

`default_nettype wire

// File: source/bch_key_bma.sv
`timescale 1ns/1ps
`default_nettype none

module bch_key_bma
	import bch_pkg::*;
(
	input wire clk,
	input wire rst,
	input wire syn_start,
	input wire syn_vec_t syndromes,
	output logic sigma_done,
	output sigma_t sigma
);

	logic busy;
	logic upd_cycle;
	logic [iter_w-1:0] iter;
	logic [l_w-1:0] l;
	gf_elem d_r;
	gf_elem d_p;
	sigma_t beta;
	gf_elem [2*t-2:0] window;
	gf_elem d_next;
	sigma_t sigma_next;
	logic bsel;

	bch_syndrome_shuffle u_shuffle (
		.clk(clk),
		.start(syn_start),
		.ce(busy && upd_cycle),
		.syndromes(syndromes),
		.window(window)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Datapath.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Discrepancy d_r = sum of sigma_i * S(2r-i+1).
	always_comb begin
		d_next = '0;
		for (int i = 0; i <= t; i++)
			d_next = d_next ^ gf_mul(sigma[i], window[i]);
	end

	// Inversionless step: sigma' = d_p * sigma + d_r * beta.
	always_comb begin
		for (int i = 0; i <= t; i++)
			sigma_next[i] = gf_mul(d_p, sigma[i]) ^ gf_mul(d_r, beta[i]);
	end

	// The old sigma becomes the new beta when the discrepancy is nonzero and
	// the iteration has caught up with the current degree.
	assign bsel = (d_r != '0) && ({1'b0, iter} >= l);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Control. Each iteration is a discrepancy cycle followed by an update.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			upd_cycle <= 1'b0;
			iter <= '0;
			sigma_done <= 1'b0;
		end else if (syn_start) begin
			busy <= 1'b1;
			upd_cycle <= 1'b0;
			iter <= '0;
			sigma_done <= 1'b0;
		end else begin
			sigma_done <= busy && upd_cycle && (iter == iter_w'(t - 1));
			if (busy)
				upd_cycle <= !upd_cycle;
			if (busy && upd_cycle) begin
				iter <= iter + 1'b1;
				if (iter == iter_w'(t - 1))
					busy <= 1'b0;
			end
		end
	end

	// The state starts one step before the usual S1 initialization. The first
	// iteration then yields sigma = 1 + S1*x and beta = x^2 (S1 nonzero) or
	// x^3, with l and d_p set to match.
	always_ff @(posedge clk) begin
		if (syn_start) begin
			sigma <= sigma_t'(1);
			beta <= sigma_t'(1 << m);
			l <= '0;
			d_p <= gf_elem'(1);
		end else if (busy && !upd_cycle) begin
			d_r <= d_next;
		end else if (busy) begin
			sigma <= sigma_next;
			if (bsel) begin
				beta <= {sigma[t-2:0], gf_elem'(0), gf_elem'(0)};
				l <= {iter, 1'b1} - l;
				d_p <= d_r;
			end else begin
				beta <= {beta[t-2:0], gf_elem'(0), gf_elem'(0)};
			end
		end
	end

endmodule

`default_nettype wire

// File: source/bch_chien_search.sv
`timescale 1ns/1ps
`default_nettype none

module bch_chien_search
	import bch_pkg::*;
(
	input wire clk,
	input wire rst,
	input wire start,
	input wire sigma_done,
	input wire sigma_t sigma,
	input wire word_t word_q,
	output logic done,
	output word_t corrected,
	output logic uncorrectable
);

	sigma_t terms;
	sigma_t terms_next;
	word_t orig;
	word_t work;
	word_t work_next;
	logic busy;
	logic start_q;
	logic is_root;
	logic [cnt_w-1:0] pos;
	logic [cnt_w-1:0] roots;
	logic [cnt_w-1:0] roots_next;
	logic [cnt_w-1:0] sigma_deg;
	logic [cnt_w-1:0] deg_next;

	// Term i holds sigma_i * alpha^(-i*k), so the sum is sigma(alpha^-k).
	// A zero sum makes alpha^k an error locator, which means bit k is wrong.
	always_comb begin
		gf_elem sum;
		sum = '0;
		for (int i = 0; i <= t; i++) begin
			sum = sum ^ terms[i];
			terms_next[i] = gf_mul(terms[i], gf_alpha_pow(n - i));
		end
		is_root = (sum == '0);
	end

	always_comb begin
		work_next = work;
		if (is_root)
			work_next[pos] = !work[pos];
	end

	assign roots_next = roots + cnt_w'(is_root);

	// Degree of sigma is the index of its highest nonzero coefficient.
	always_comb begin
		deg_next = '0;
		for (int i = 1; i <= t; i++) begin
			if (sigma[i] != '0)
				deg_next = cnt_w'(i);
		end
	end

	// A new start aborts the search. start_q masks a sigma_done that the
	// solver had already scheduled for the word being dropped.
	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			start_q <= 1'b0;
			done <= 1'b0;
			corrected <= '0;
			uncorrectable <= 1'b0;
		end else begin
			start_q <= start;
			done <= 1'b0;
			if (start) begin
				busy <= 1'b0;
			end else if (sigma_done && !start_q) begin
				busy <= 1'b1;
			end else if (busy && (pos == cnt_w'(n - 1))) begin
				busy <= 1'b0;
				done <= 1'b1;
				uncorrectable <= (roots_next != sigma_deg);
				corrected <= (roots_next == sigma_deg) ? work_next : orig;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (sigma_done) begin
			terms <= sigma;
			orig <= word_q;
			work <= word_q;
			pos <= '0;
			roots <= '0;
			sigma_deg <= deg_next;
		end else if (busy) begin
			terms <= terms_next;
			work <= work_next;
			pos <= pos + 1'b1;
			roots <= roots_next;
		end
	end

endmodule

`default_nettype wire

// File: source/bch_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module bch_decoder
	import bch_pkg::*;
(
	input wire clk,
	input wire rst,
	input wire start,
	input wire word_t received,
	output logic done,
	output word_t corrected,
	output logic uncorrectable
);

	logic syn_start;
	syn_vec_t syndromes;
	word_t word_q;
	logic sigma_done;
	sigma_t sigma;

	// Syndromes, then the key equation, then the root search.
	bch_syndrome u_syndrome (
		.clk(clk),
		.rst(rst),
		.start(start),
		.received(received),
		.syn_start(syn_start),
		.syndromes(syndromes),
		.word_q(word_q)
	);

	bch_key_bma u_key_bma (
		.clk(clk),
		.rst(rst),
		.syn_start(syn_start),
		.syndromes(syndromes),
		.sigma_done(sigma_done),
		.sigma(sigma)
	);

	bch_chien_search u_chien (
		.clk(clk),
		.rst(rst),
		.start(start),
		.sigma_done(sigma_done),
		.sigma(sigma),
		.word_q(word_q),
		.done(done),
		.corrected(corrected),
		.uncorrectable(uncorrectable)
	);

endmodule

`default_nettype wire

// File: test/bch_decoder_chk.sv
`timescale 1ns/1ps
`default_nettype none

module bch_decoder_chk
	import bch_pkg::*;
(
	input wire clk,
	input wire rst,
	input wire start,
	input wire done,
	input wire word_t corrected,
	input wire uncorrectable,
	input wire sigma_done,
	input wire sigma_t sigma
);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Handshake.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	a_done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
		else $error("done stayed high for more than one cycle");

	// The latest start is always 24 cycles behind done, restarts included.
	a_latency: assert property (@(posedge clk) disable iff (rst) done |-> $past(start, 24))
		else $error("done did not arrive 24 cycles after start");

	a_known: assert property (@(posedge clk) disable iff (rst)
		!$isunknown({done, corrected, uncorrectable}))
		else $error("decoder output is unknown after reset");

	// Sigma_0 is a product of nonzero discrepancies.
	a_sigma0: assert property (@(posedge clk) disable iff (rst)
		sigma_done |-> (sigma[0] != '0))
		else $error("sigma constant term is zero at sigma_done");

endmodule

bind bch_decoder bch_decoder_chk u_chk (
	.clk(clk),
	.rst(rst),
	.start(start),
	.done(done),
	.corrected(corrected),
	.uncorrectable(uncorrectable),
	.sigma_done(sigma_done),
	.sigma(sigma)
);

`default_nettype wire

// File: test/bch_decoder_tb.sv
`timescale 1ns/1ps
`default_nettype none

module bch_decoder_tb
	import bch_pkg::*;
();

	logic clk = 1'b0;
	logic rst;
	logic start;
	word_t received;
	logic done;
	word_t corrected;
	logic uncorrectable;
	logic [31:0] lcg_state;

	bch_decoder UUT (
		.clk(clk),
		.rst(rst),
		.start(start),
		.received(received),
		.done(done),
		.corrected(corrected),
		.uncorrectable(uncorrectable)
	);

	always #2 clk = ~clk;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic stop_with_fail();
		$display("RESULT: FAIL");
		$fatal(1, "Stopped at the first error.");
	endtask

	task automatic check_word(input string name, input word_t exp, input word_t act);
		if (act !== exp) begin
			$display("MISMATCH %s: expected %h, actual %h", name, exp, act);
			stop_with_fail();
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("MISMATCH %s: expected %b, actual %b", name, exp, act);
			stop_with_fail();
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stimulus helpers. All of them start and end on a falling edge.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic run_decode(input word_t rx, output word_t got, output logic flag);
		int cycles;
		start = 1'b1;
		received = rx;
		@(negedge clk);
		start = 1'b0;
		cycles = 0;
		while (done !== 1'b1) begin
			if (cycles >= 100) begin
				$display("Timeout: done did not rise within 100 cycles of start.");
				stop_with_fail();
			end else begin
				@(negedge clk);
				cycles++;
			end
		end
		got = corrected;
		flag = uncorrectable;
		@(negedge clk);
	endtask

	task automatic decode_check(input string name, input word_t rx, input word_t exp_w,
			input logic exp_f);
		word_t got;
		logic flag;
		run_decode(rx, got, flag);
		check_word(name, exp_w, got);
		check_flag(name, exp_f, flag);
	endtask

	// Picks 0 to 3 distinct error positions.
	task automatic random_pattern(output word_t pat);
		int weight;
		int pos;
		pat = '0;
		lcg_state = lcg_next(lcg_state);
		weight = int'(lcg_state[31:16]) % 4;
		while ($countones(pat) < weight) begin
			lcg_state = lcg_next(lcg_state);
			pos = int'(lcg_state[31:16]) % n;
			pat[pos] = 1'b1;
		end
	endtask

	// The first word is abandoned after gap cycles; only the second may come out.
	task automatic restart_check(input string name, input word_t first_rx,
			input word_t second_rx, input word_t exp_w, input int gap);
		start = 1'b1;
		received = first_rx;
		@(negedge clk);
		start = 1'b0;
		repeat (gap - 1) begin
			@(negedge clk);
			check_flag({name, "_early_done"}, 1'b0, done);
		end
		decode_check(name, second_rx, exp_w, 1'b0);
	endtask

	initial begin
		int fd;
		int count;
		string line;
		string case_name;
		logic [8*32-1:0] name_buf;
		word_t cw;
		word_t err;
		word_t exp_w;
		word_t pat;
		logic exp_f;
		word_t cw_list[$];
		rst = 1'b1;
		start = 1'b0;
		received = '0;
		lcg_state = 32'h16c6f780;
		repeat (4) @(negedge clk);
		rst = 1'b0;
		repeat (8) begin
			@(negedge clk);
			check_flag("reset_idle", 1'b0, done);
		end

		fd = $fopen("test/bch_cases.txt", "r");
		if (fd == 0) begin
			$display("Could not open test/bch_cases.txt for reading.");
			stop_with_fail();
		end
		while ($fgets(line, fd) > 0) begin
			if (line.getc(0) != "#") begin
				name_buf = '0;
				count = $sscanf(line, "%s %h %h %h %h", name_buf, cw, err, exp_w, exp_f);
				if (count == 5) begin
					case_name = string'(name_buf);
					decode_check({case_name, "_clean"}, cw, cw, 1'b0);
					if (err != '0)
						decode_check(case_name, cw ^ err, exp_w, exp_f);
					// Anything within three errors must come back as the codeword.
					repeat (err == '0 ? 16 : 4) begin
						random_pattern(pat);
						decode_check({case_name, "_random"}, cw ^ pat, cw, 1'b0);
					end
					cw_list.push_back(cw);
				end else if (count > 0) begin
					$display("Malformed line in test/bch_cases.txt: %s", line);
					stop_with_fail();
				end
			end
		end
		$fclose(fd);
		if (cw_list.size() < 2) begin
			$display("Fewer than two cases were read from test/bch_cases.txt.");
			stop_with_fail();
		end

		// Restart once inside the solver and once inside the Chien search.
		restart_check("restart_bma", cw_list[0] ^ 15'h000F, cw_list[1] ^ 15'h0100,
			cw_list[1], 4);
		restart_check("restart_chien", cw_list[1] ^ 15'h000F, cw_list[0] ^ 15'h0002,
			cw_list[0], 20);

		$display("RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// File: bch_decoder.f
source/bch_pkg.sv
source/bch_syndrome.sv
source/bch_syndrome_shuffle.sv
source/bch_key_bma.sv
source/bch_chien_search.sv
source/bch_decoder.sv
test/bch_decoder_chk.sv
test/bch_decoder_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the BCH decoder testbench with Verilator and runs it from the project root.
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module bch_decoder_tb -f bch_decoder.f \
	--Mdir obj_dir -o bch_decoder_sim
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit "$status"
fi

./obj_dir/bch_decoder_sim
status=$?
if [ "$status" -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit "$status"
fi

exit 0

// File: test/bch_cases.txt
# Columns: name, codeword, error pattern (0 = random), expected word, expected flag.
# Words are hex with bit i the coefficient of x^i; codewords are multiples of g = 0x0537.
zero_random     0000 0000 0000 0
gen_one_err     0537 0001 0537 0
xg_two_err      0A6E 4001 0A6E 0
x2g_three_err   14DC 0841 14DC 0
ones_three_err  7FFF 7000 7FFF 0
x4g_two_err     5370 2100 5370 0
sum_random      0F59 0000 0F59 0
x3g_random      29B8 0000 29B8 0
zero_w4_fail    0000 000F 000F 1
ones_w4_fail    7FFF 000F 7FF0 1
xg_w4_fail      0A6E 00F0 0A9E 1
zero_w4_mis     0000 0017 0537 0
xg_w4_mis       0A6E 0017 0F59 0
zero_w5_mis     0000 0037 0537 0
